/* source/gbc_io_pkg.sv */
`default_nettype none

package gbc_io_pkg;

   // ==========================================================
   // I/O page address map
   // ==========================================================
   localparam logic [7:0] IO_PAGE = 8'hFF;

   // low address byte of each register
   localparam logic [7:0] REG_DIV      = 8'h04;
   localparam logic [7:0] REG_TIMA     = 8'h05;
   localparam logic [7:0] REG_TMA      = 8'h06;
   localparam logic [7:0] REG_TAC      = 8'h07;
   localparam logic [7:0] REG_IF       = 8'h0F;
   localparam logic [7:0] REG_IE       = 8'hFF;
   localparam logic [7:0] REG_SPARE_6C = 8'h6C;
   localparam logic [7:0] REG_SPARE_72 = 8'h72;
   localparam logic [7:0] REG_SPARE_73 = 8'h73;
   localparam logic [7:0] REG_SPARE_74 = 8'h74;
   localparam logic [7:0] REG_SPARE_75 = 8'h75;
   localparam logic [7:0] REG_SPARE_76 = 8'h76;
   localparam logic [7:0] REG_SPARE_77 = 8'h77;

   // read-back and reset values
   localparam logic [7:0] IF_READ_ONES   = 8'hE0;
   localparam logic [7:0] SPARE_6C_RESET = 8'hFE;
   localparam logic [7:0] SPARE_75_RESET = 8'h8F;
   localparam logic [7:0] SPARE_6C_MASK  = 8'h01;
   localparam logic [7:0] SPARE_75_MASK  = 8'h70;
   localparam logic [7:0] UNMAPPED_DATA  = 8'hFF;

   // ==========================================================
   // timer rates and interrupt bits
   // ==========================================================
   localparam int unsigned DIV_STEP_CYCLES = 256;
   // cycles per TIMA step, entry picked by TAC clock select
   localparam logic [3:0][15:0] TIMA_RATE = {16'd256, 16'd64, 16'd16, 16'd1024};

   localparam int unsigned INT_TIMER = 2;

   // ==========================================================
   // types
   // ==========================================================
   typedef struct packed {
      logic       wr;
      logic       rd;
      logic [7:0] index;
      logic [7:0] wdata;
   } io_req_t;

   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic [4:0] unused;
         logic       enable;
         logic [1:0] clock_select;
      } fields;
   } tac_u;

   typedef struct packed {
      logic [7:0] spare_6c;
      logic [7:0] spare_72;
      logic [7:0] spare_73;
      logic [7:0] spare_74;
      logic [7:0] spare_75;
      logic [7:0] spare_76;
      logic [7:0] spare_77;
   } spare_regs_t;

   typedef struct packed {
      logic [7:0]  div;
      logic [7:0]  tima;
      logic [7:0]  tma;
      tac_u        tac;
      logic [4:0]  if_flags;
      logic [4:0]  ie_mask;
      spare_regs_t spare;
   } io_regs_t;

endpackage

`default_nettype wire

/* source/io_bus_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module io_bus_decode import gbc_io_pkg::*; (
   input  wire logic        clock,
   input  wire logic        reset,
   input  wire logic [15:0] addr,
   input  wire logic [7:0]  wdata,
   input  wire logic        we_l,
   input  wire logic        re_l,
   output io_req_t          req
);

   // sampled strobes, active high, and their previous sample
   logic        we_s;
   logic        re_s;
   logic        we_prev;
   logic        re_prev;
   logic [15:0] addr_q;
   logic [7:0]  wdata_q;
   logic        page_hit;

   always_ff @(posedge clock) begin
      if (reset) begin
         we_s    <= 1'b0;
         re_s    <= 1'b0;
         we_prev <= 1'b0;
         re_prev <= 1'b0;
      end else begin
         we_s    <= ~we_l;
         re_s    <= ~re_l;
         we_prev <= we_s;
         re_prev <= re_s;
      end
      addr_q  <= addr;
      wdata_q <= wdata;
   end

   assign page_hit = (addr_q[15:8] == IO_PAGE);

   // one request per falling strobe; write wins when both are low
   assign req.wr    = page_hit & we_s & ~we_prev;
   assign req.rd    = page_hit & re_s & ~re_prev & ~we_s;
   assign req.index = addr_q[7:0];
   assign req.wdata = wdata_q;

endmodule

`default_nettype wire

/* source/timer_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module timer_unit import gbc_io_pkg::*; (
   input  wire logic    clock,
   input  wire logic    reset,
   input  wire io_req_t req,
   output logic [7:0]   div,
   output logic [7:0]   tima,
   output logic [7:0]   tma,
   output tac_u         tac,
   output logic         timer_irq
);

   logic [15:0] divider;
   logic [15:0] rate_mask;
   logic        tima_tick;
   logic [8:0]  tima_next;
   tac_u        tac_in;
   logic        wr_div;
   logic        wr_tima;
   logic        wr_tma;
   logic        wr_tac;

   // ==========================================================
   // write decode
   // ==========================================================
   assign wr_div  = req.wr && (req.index == REG_DIV);
   assign wr_tima = req.wr && (req.index == REG_TIMA);
   assign wr_tma  = req.wr && (req.index == REG_TMA);
   assign wr_tac  = req.wr && (req.index == REG_TAC);

   // bus data seen as a TAC word
   assign tac_in.raw = req.wdata;

   // DIV is the divider byte above the step count
   assign div = divider[$clog2(DIV_STEP_CYCLES) +: 8];

   // ==========================================================
   // TIMA step select
   // ==========================================================
   // tick once the low divider bits wrap for the selected rate
   assign rate_mask = TIMA_RATE[tac.fields.clock_select] - 16'd1;
   assign tima_tick = tac.fields.enable && ((divider & rate_mask) == rate_mask);
   assign tima_next = {1'b0, tima} + 9'd1;

   always_ff @(posedge clock) begin
      if (reset) begin
         divider   <= '0;
         tima      <= '0;
         tma       <= '0;
         tac.raw   <= '0;
         timer_irq <= 1'b0;
      end else begin
         timer_irq <= 1'b0;

         // any DIV write clears the whole divider
         if (wr_div) begin
            divider <= '0;
         end else begin
            divider <= divider + 16'd1;
         end

         // bus write beats count and reload
         if (wr_tima) begin
            tima <= req.wdata;
         end else if (tima_tick) begin
            if (tima_next[8]) begin
               tima      <= tma;
               timer_irq <= 1'b1;
            end else begin
               tima <= tima_next[7:0];
            end
         end

         if (wr_tma) begin
            tma <= req.wdata;
         end

         // only enable and clock select are stored
         if (wr_tac) begin
            tac.fields.unused       <= '0;
            tac.fields.enable       <= tac_in.fields.enable;
            tac.fields.clock_select <= tac_in.fields.clock_select;
         end
      end
   end

endmodule

`default_nettype wire

/* source/interrupt_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module interrupt_unit import gbc_io_pkg::*; (
   input  wire logic       clock,
   input  wire logic       reset,
   input  wire io_req_t    req,
   input  wire logic [3:0] int_req,
   input  wire logic       timer_irq,
   output logic [4:0]      if_flags,
   output logic [4:0]      ie_mask,
   output logic            irq
);

   logic [4:0] set_bits;
   logic       wr_if;
   logic       wr_ie;

   assign wr_if = req.wr && (req.index == REG_IF);
   assign wr_ie = req.wr && (req.index == REG_IE);

   // IF order: vblank, lcdstat, timer, serial, joypad
   always_comb begin
      set_bits            = {int_req[3:2], 1'b0, int_req[1:0]};
      set_bits[INT_TIMER] = timer_irq;
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         if_flags <= '0;
         ie_mask  <= '0;
      end else begin
         // a request in the write cycle is not lost
         if (wr_if) begin
            if_flags <= req.wdata[4:0] | set_bits;
         end else begin
            if_flags <= if_flags | set_bits;
         end

         if (wr_ie) begin
            ie_mask <= req.wdata[4:0];
         end
      end
   end

   // pending and enabled
   assign irq = |(if_flags & ie_mask);

endmodule

`default_nettype wire

/* source/spare_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module spare_registers import gbc_io_pkg::*; (
   input  wire logic    clock,
   input  wire logic    reset,
   input  wire io_req_t req,
   output spare_regs_t  spare
);

   // only the writable bits of 6C and 75 are kept
   logic [7:0] bits_6c;
   logic [7:0] bits_75;
   logic [7:0] reg_72;
   logic [7:0] reg_73;
   logic [7:0] reg_74;

   // fixed bits from the reset value, the rest from storage
   function automatic logic [7:0] merge_bits(
      input logic [7:0] reset_val,
      input logic [7:0] mask,
      input logic [7:0] stored
   );
      merge_bits = (reset_val & ~mask) | (stored & mask);
   endfunction

   always_ff @(posedge clock) begin
      if (reset) begin
         bits_6c <= SPARE_6C_RESET & SPARE_6C_MASK;
         bits_75 <= SPARE_75_RESET & SPARE_75_MASK;
         reg_72  <= '0;
         reg_73  <= '0;
         reg_74  <= '0;
      end else if (req.wr) begin
         case (req.index)
            REG_SPARE_6C: bits_6c <= req.wdata & SPARE_6C_MASK;
            REG_SPARE_72: reg_72  <= req.wdata;
            REG_SPARE_73: reg_73  <= req.wdata;
            REG_SPARE_74: reg_74  <= req.wdata;
            REG_SPARE_75: bits_75 <= req.wdata & SPARE_75_MASK;
            default: ;
         endcase
      end
   end

   always_comb begin
      spare.spare_6c = merge_bits(SPARE_6C_RESET, SPARE_6C_MASK, bits_6c);
      spare.spare_72 = reg_72;
      spare.spare_73 = reg_73;
      spare.spare_74 = reg_74;
      spare.spare_75 = merge_bits(SPARE_75_RESET, SPARE_75_MASK, bits_75);
      // read-only pair, writes have no effect
      spare.spare_76 = 8'h00;
      spare.spare_77 = 8'h00;
   end

endmodule

`default_nettype wire

/* source/io_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module io_read_mux import gbc_io_pkg::*; (
   input  wire logic       clock,
   input  wire logic       reset,
   input  wire io_req_t    req,
   input  wire io_regs_t   regs,
   input  wire logic [7:0] dbg_select,
   output logic [7:0]      rdata,
   output logic [7:0]      dbg_data
);

   logic [7:0] bus_value;
   logic [7:0] dbg_value;

   // ==========================================================
   // register map, shared by bus and debug view
   // ==========================================================
   function automatic logic [7:0] read_map(
      input io_regs_t   r,
      input logic [7:0] index
   );
      case (index)
         REG_DIV:      read_map = r.div;
         REG_TIMA:     read_map = r.tima;
         REG_TMA:      read_map = r.tma;
         REG_TAC:      read_map = r.tac.raw;
         // upper IF bits always read as ones
         REG_IF:       read_map = IF_READ_ONES | {3'b000, r.if_flags};
         REG_IE:       read_map = {3'b000, r.ie_mask};
         REG_SPARE_6C: read_map = r.spare.spare_6c;
         REG_SPARE_72: read_map = r.spare.spare_72;
         REG_SPARE_73: read_map = r.spare.spare_73;
         REG_SPARE_74: read_map = r.spare.spare_74;
         REG_SPARE_75: read_map = r.spare.spare_75;
         REG_SPARE_76: read_map = r.spare.spare_76;
         REG_SPARE_77: read_map = r.spare.spare_77;
         default:      read_map = UNMAPPED_DATA;
      endcase
   endfunction

   assign bus_value = read_map(regs, req.index);
   assign dbg_value = read_map(regs, dbg_select);

   // bus read data holds until the next read
   always_ff @(posedge clock) begin
      if (reset) begin
         rdata <= '0;
      end else if (req.rd) begin
         rdata <= bus_value;
      end
   end

   // debug view follows the select every cycle
   always_ff @(posedge clock) begin
      if (reset) begin
         dbg_data <= '0;
      end else begin
         dbg_data <= dbg_value;
      end
   end

endmodule

`default_nettype wire

/* source/gbc_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gbc_io_top import gbc_io_pkg::*; (
   input  wire logic        clock,
   input  wire logic        reset,
   input  wire logic [15:0] addr,
   input  wire logic [7:0]  wdata,
   input  wire logic        we_l,
   input  wire logic        re_l,
   input  wire logic [3:0]  int_req,
   input  wire logic [7:0]  dbg_select,
   output logic [7:0]       rdata,
   output logic [7:0]       dbg_data,
   output logic             irq
);

   wire io_req_t  req;
   wire io_regs_t regs;
   wire logic     timer_irq;

   // ==========================================================
   // bus input side
   // ==========================================================
   io_bus_decode u_decode (
      .clock (clock),
      .reset (reset),
      .addr  (addr),
      .wdata (wdata),
      .we_l  (we_l),
      .re_l  (re_l),
      .req   (req)
   );

   // ==========================================================
   // register blocks
   // ==========================================================
   timer_unit u_timer (
      .clock     (clock),
      .reset     (reset),
      .req       (req),
      .div       (regs.div),
      .tima      (regs.tima),
      .tma       (regs.tma),
      .tac       (regs.tac),
      .timer_irq (timer_irq)
   );

   interrupt_unit u_interrupt (
      .clock     (clock),
      .reset     (reset),
      .req       (req),
      .int_req   (int_req),
      .timer_irq (timer_irq),
      .if_flags  (regs.if_flags),
      .ie_mask   (regs.ie_mask),
      .irq       (irq)
   );

   spare_registers u_spare (
      .clock (clock),
      .reset (reset),
      .req   (req),
      .spare (regs.spare)
   );

   // read data and debug view
   io_read_mux u_read_mux (
      .clock      (clock),
      .reset      (reset),
      .req        (req),
      .regs       (regs),
      .dbg_select (dbg_select),
      .rdata      (rdata),
      .dbg_data   (dbg_data)
   );

endmodule

`default_nettype wire

/* verif/gbc_io_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module gbc_io_chk import gbc_io_pkg::*; (
   input wire logic       clock,
   input wire logic       reset,
   input wire io_req_t    req,
   input wire logic [4:0] ie_mask,
   input wire logic       irq
);

   int unsigned failures = 0;

   wr_rd_exclusive: assert property (@(posedge clock) disable iff (reset) !(req.wr && req.rd))
      else begin
         $error("write and read request high in the same cycle");
         failures++;
      end

   // each decoded request lasts one cycle
   wr_single_cycle: assert property (@(posedge clock) disable iff (reset) req.wr |=> !req.wr)
      else begin
         $error("write request held longer than one cycle");
         failures++;
      end

   rd_single_cycle: assert property (@(posedge clock) disable iff (reset) req.rd |=> !req.rd)
      else begin
         $error("read request held longer than one cycle");
         failures++;
      end

   irq_needs_enable: assert property (@(posedge clock) disable iff (reset)
                                      (ie_mask == 5'b00000) |-> !irq)
      else begin
         $error("irq high while no interrupt is enabled");
         failures++;
      end

endmodule

`default_nettype wire

/* verif/tb_gbc_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gbc_io import gbc_io_pkg::*;;

   typedef struct packed {
      logic [7:0]  test;
      logic [3:0]  op;
      logic [15:0] addr;
      logic [15:0] data;
      logic [15:0] exp_val;
   } stim_t;

   logic        clock;
   logic        reset;
   logic [15:0] addr;
   logic [7:0]  wdata;
   logic        we_l;
   logic        re_l;
   logic [3:0]  int_req;
   logic [7:0]  dbg_select;
   logic [7:0]  rdata;
   logic [7:0]  dbg_data;
   logic        irq;

   stim_t       ops[$];
   logic [31:0] rng_state;
   logic [7:0]  spare_model [0:255];
   int          errors = 0;
   int          checks = 0;
   int          test_errors = 0;
   int          test_checks = 0;
   int          tests_done = 0;
   int          cycles = 0;
   int          cycle_limit = 0;

   gbc_io_top UUT (
      .clock      (clock),
      .reset      (reset),
      .addr       (addr),
      .wdata      (wdata),
      .we_l       (we_l),
      .re_l       (re_l),
      .int_req    (int_req),
      .dbg_select (dbg_select),
      .rdata      (rdata),
      .dbg_data   (dbg_data),
      .irq        (irq)
   );

   // decoded request and IE are both visible at the interrupt unit
   bind interrupt_unit gbc_io_chk u_interrupt_chk (
      .clock   (clock),
      .reset   (reset),
      .req     (req),
      .ie_mask (ie_mask),
      .irq     (irq)
   );

   initial begin
      clock = 1'b0;
      forever #5 clock = ~clock;
   end

   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
         $display("Result: FAILED");
         $finish;
      end
   end

   // ==========================================================
   // helpers
   // ==========================================================
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // value a spare register reads back after a write of d
   function automatic logic [7:0] spare_readback(input logic [7:0] index, input logic [7:0] d);
      case (index)
         REG_SPARE_6C: return (SPARE_6C_RESET & ~SPARE_6C_MASK) | (d & SPARE_6C_MASK);
         REG_SPARE_75: return (SPARE_75_RESET & ~SPARE_75_MASK) | (d & SPARE_75_MASK);
         REG_SPARE_76: return 8'h00;
         REG_SPARE_77: return 8'h00;
         default:      return d;
      endcase
   endfunction

   task automatic check_value(input logic [7:0] actual, input logic [7:0] expected,
                              input string what);
      checks++;
      test_checks++;
      if (actual !== expected) begin
         errors++;
         test_errors++;
         $display("error at %0d ns: %s is %02h, expected %02h", $time, what, actual, expected);
      end
   endtask

   task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
      addr  = a;
      wdata = d;
      we_l  = 1'b0;
      @(posedge clock);
      @(negedge clock);
      we_l = 1'b1;
      @(negedge clock);
   endtask

   // rdata is loaded on the second edge after the strobe
   task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
      addr = a;
      re_l = 1'b0;
      @(posedge clock);
      @(negedge clock);
      re_l = 1'b1;
      @(posedge clock);
      @(negedge clock);
      d = rdata;
   endtask

   task automatic pulse_requests(input logic [3:0] bits);
      int_req = bits;
      @(negedge clock);
      int_req = 4'h0;
      @(negedge clock);
   endtask

   // clear the divider and let it run one full DIV step
   task automatic verify_div_count();
      logic [7:0] got;
      bus_write({IO_PAGE, REG_DIV}, 8'h00);
      repeat (DIV_STEP_CYCLES) @(negedge clock);
      bus_read({IO_PAGE, REG_DIV}, got);
      check_value(got, 8'h01, "DIV one step after a clear");
   endtask

   task automatic report_test(input logic [7:0] number);
      $display("test %0d finished: %0d checks, %0d errors", number, test_checks, test_errors);
      tests_done++;
      test_checks = 0;
      test_errors = 0;
   endtask

   // ==========================================================
   // one stimulus line
   // ==========================================================
   task automatic run_op(input stim_t s);
      logic [7:0] d;
      logic [7:0] got;
      logic [7:0] want;
      want = (s.exp_val == 16'h100) ? spare_model[s.addr[7:0]] : s.exp_val[7:0];
      case (s.op)
         4'h0: begin
            d = s.data[7:0];
            if (s.data == 16'h100) begin
               rng_state = xorshift32(rng_state);
               d = rng_state[7:0];
               spare_model[s.addr[7:0]] = spare_readback(s.addr[7:0], d);
            end
            if (s.addr == {IO_PAGE, REG_DIV}) begin
               verify_div_count();
            end
            bus_write(s.addr, d);
         end
         4'h1: begin
            bus_read(s.addr, got);
            check_value(got, want, $sformatf("read of %04h", s.addr));
         end
         4'h2: begin
            dbg_select = s.addr[7:0];
            bus_read(s.addr, got);
            check_value(got, want, $sformatf("read of %04h", s.addr));
            check_value(dbg_data, want, $sformatf("debug view of index %02h", s.addr[7:0]));
         end
         4'h3: pulse_requests(s.data[3:0]);
         4'h4: repeat (s.data) @(negedge clock);
         4'h5: check_value({7'b0000000, irq}, s.exp_val[7:0], "irq level");
         default: begin
            $display("stimulus line with unknown operation %0h", s.op);
            errors++;
         end
      endcase
   endtask

   initial begin
      int fd;
      int t;
      int o;
      int a;
      int d;
      int e;
      int wait_sum;
      int line_count;
      int assert_fails;
      logic [8*100-1:0] line;
      reset      = 1'b1;
      addr       = 16'h0000;
      wdata      = 8'h00;
      we_l       = 1'b1;
      re_l       = 1'b1;
      int_req    = 4'h0;
      dbg_select = 8'h00;
      rng_state  = 32'd58;
      wait_sum   = 0;
      line_count = 0;

      fd = $fopen("verif/gbc_io_stimulus.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file verif/gbc_io_stimulus.txt");
         errors++;
      end else begin
         while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
               line_count++;
               if ($sscanf(line, "%h %h %h %h %h", t, o, a, d, e) == 5) begin
                  ops.push_back('{t[7:0], o[3:0], a[15:0], d[15:0], e[15:0]});
                  if (o == 4) begin
                     wait_sum += d;
                  end
                  // a DIV write first runs one full DIV step
                  if (o == 0 && a == {IO_PAGE, REG_DIV}) begin
                     wait_sum += DIV_STEP_CYCLES;
                  end
               end
            end
         end
         $fclose(fd);
         if (ops.size() == 0) begin
            $display("the stimulus file holds no operations");
            errors++;
         end
      end
      cycle_limit = 2 * wait_sum + 8 * line_count + 16;

      repeat (8) @(negedge clock);
      reset = 1'b0;
      @(negedge clock);

      foreach (ops[i]) begin
         if (i > 0 && ops[i].test != ops[i-1].test) begin
            report_test(ops[i-1].test);
         end
         run_op(ops[i]);
      end
      if (ops.size() > 0) begin
         report_test(ops[ops.size()-1].test);
      end

      assert_fails = UUT.u_interrupt.u_interrupt_chk.failures;
      if (assert_fails > 0) begin
         $display("%0d assertion failures in the bound checkers", assert_fails);
         errors += assert_fails;
      end

      $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verif/gbc_io_stimulus.txt */
# columns: test op addr data expected, all hex
# op 0 write, 1 read, 2 debug view, 3 int_req pulse, 4 wait cycles, 5 irq; 100 = random or computed
1 1 ff04 0 00
1 1 ff05 0 00
1 1 ff06 0 00
1 1 ff07 0 00
1 1 ff0f 0 e0
1 1 ffff 0 00
1 1 ff6c 0 fe
1 1 ff72 0 00
1 1 ff73 0 00
1 1 ff74 0 00
1 1 ff75 0 8f
1 1 ff76 0 00
1 1 ff77 0 00
2 0 ff6c 100 0
2 0 ff73 100 0
2 0 ff75 100 0
2 0 ff77 100 0
2 1 ff6c 0 100
2 1 ff73 0 100
2 1 ff75 0 100
2 1 ff76 0 00
2 1 ff77 0 100
2 1 ff00 0 ff
2 1 ff50 0 ff
3 0 ff06 fe 0
3 0 ff05 fe 0
3 0 ffff 04 0
3 0 ff07 05 0
3 4 0 64 0
3 5 0 0 01
3 1 ff0f 0 e4
3 0 ff04 3c 0
3 1 ff04 0 00
4 0 ff07 00 0
4 0 ff0f 00 0
4 3 0 1 0
4 1 ff0f 0 e1
4 5 0 0 00
4 0 ffff 01 0
4 5 0 0 01
4 0 ff0f 00 0
4 5 0 0 00
4 3 0 4 0
4 1 ff0f 0 e8
4 5 0 0 00
5 0 ff05 5a 0
5 0 ff04 00 0
5 2 ff04 0 00
5 2 ff05 0 5a
5 2 ff07 0 00
5 2 ff0f 0 e8
5 2 ffff 0 01
5 2 ff6c 0 100
5 2 ff75 0 100
5 2 ff77 0 00

/* compile.f */
source/gbc_io_pkg.sv
source/io_bus_decode.sv
source/timer_unit.sv
source/interrupt_unit.sv
source/spare_registers.sv
source/io_read_mux.sv
source/gbc_io_top.sv
verif/gbc_io_chk.sv
verif/tb_gbc_io.sv

/* Bender.yml */
package:
  name: gbc_io

sources:
  - source/gbc_io_pkg.sv
  - source/io_bus_decode.sv
  - source/timer_unit.sv
  - source/interrupt_unit.sv
  - source/spare_registers.sv
  - source/io_read_mux.sv
  - source/gbc_io_top.sv
  - target: test
    files:
      - verif/gbc_io_chk.sv
      - verif/tb_gbc_io.sv
